// ==== hdl/mpram_5r1w.sv ====
`timescale 1ns/1ns

module mpram_5r1w
(
   input  logic               clk,
   input  logic               arst_n,
   input  mpram_pkg::wr_req_t wr_req,
   input  mpram_pkg::addr_t   lkp_addr [mpram_pkg::NRD],
   output mpram_pkg::data_t   lkp_data [mpram_pkg::NRD]
);

   // ======================================================================
   // Storage
   // ======================================================================
   mpram_pkg::data_t mem [mpram_pkg::WORDS];

   // Single write port, range already checked upstream
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int w = 0; w < mpram_pkg::WORDS; w++)
         begin
            mem[w] <= '0;
         end
      end
      else if (wr_req.valid)
      begin
         mem[wr_req.addr] <= wr_req.data;
      end
   end

   // ======================================================================
   // Lookups
   // ======================================================================
   // Five independent combinational read paths
   always_comb
   begin
      for (int i = 0; i < mpram_pkg::NRD; i++)
      begin
         lkp_data[i] = mem[lkp_addr[i]];
      end
   end

   // Read ports must clamp bad addresses before they get here
   for (genvar g = 0; g < mpram_pkg::NRD; g++)
   begin : g_lkp_chk
      a_lkp_range: assert property (
         @(posedge clk) disable iff (!arst_n)
         mpram_pkg::addr_ok(lkp_addr[g])
      );
   end

endmodule

// ==== hdl/mpram_pkg.sv ====
package mpram_pkg;

   // ======================================================================
   // Sizes
   // ======================================================================
   localparam int WIDTH = 8;   // Data word width
   localparam int WORDS = 24;  // Storage entries, not a power of two
   localparam int AW    = 5;   // Address width, codes 24..31 are illegal
   localparam int NRD   = 5;   // Read ports

   typedef logic [AW-1:0]    addr_t;
   typedef logic [WIDTH-1:0] data_t;

   // ======================================================================
   // Port payloads
   // ======================================================================
   // Registered write request, valid only for legal addresses
   typedef struct packed {
      logic  valid;
      addr_t addr;
      data_t data;
   } wr_req_t;

   // Read response
   typedef struct packed {
      logic  valid;  // Port was enabled
      logic  err;    // Address out of range
      data_t data;
   } rd_rsp_t;

   // True for an address inside the array
   function automatic logic addr_ok(input addr_t addr);
      return int'(addr) < WORDS;
   endfunction

endpackage

// ==== hdl/mpram_read_port.sv ====
`timescale 1ns/1ns

module mpram_read_port
(
   input  logic               clk,
   input  logic               arst_n,
   input  logic               oe_n,      // Active low output enable
   input  mpram_pkg::addr_t   rad,
   input  mpram_pkg::data_t   lkp_data,
   output mpram_pkg::addr_t   lkp_addr,
   output mpram_pkg::rd_rsp_t rd_rsp
);

   logic             en_q;
   logic             ok_q;
   mpram_pkg::addr_t addr_q;
   logic             rad_ok;

   assign rad_ok = mpram_pkg::addr_ok(rad);

   // ======================================================================
   // Request stage
   // ======================================================================
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         en_q   <= 1'b0;
         ok_q   <= 1'b0;
         addr_q <= '0;
      end
      else
      begin
         en_q   <= !oe_n;
         ok_q   <= rad_ok;
         addr_q <= rad_ok ? rad : '0;  // Clamp so the array index stays legal
      end
   end

   assign lkp_addr = addr_q;

   // ======================================================================
   // Response stage
   // ======================================================================
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         rd_rsp <= '0;
      else
      begin
         rd_rsp.valid <= en_q;
         rd_rsp.err   <= en_q && !ok_q;
         rd_rsp.data  <= (en_q && ok_q) ? lkp_data : '0;
      end
   end

   // Errors come only with an enabled response
   a_err_valid: assert property (
      @(posedge clk) disable iff (!arst_n)
      rd_rsp.err |-> rd_rsp.valid
   );

endmodule

// ==== hdl/mpram_top.sv ====
`timescale 1ns/1ns

module mpram_top
(
   input  logic                      clk,
   input  logic                      arst_n,

   // Write side
   input  logic                      we_n,
   input  mpram_pkg::addr_t          wad,
   input  mpram_pkg::data_t          din,
   output logic                      wr_err,
   output logic                      wr_busy,

   // Read side
   input  logic [mpram_pkg::NRD-1:0] oe_n,
   input  mpram_pkg::addr_t          rad    [mpram_pkg::NRD],
   output mpram_pkg::rd_rsp_t        rd_rsp [mpram_pkg::NRD]
);

   mpram_pkg::wr_req_t wr_req;
   mpram_pkg::addr_t   lkp_addr [mpram_pkg::NRD];
   mpram_pkg::data_t   lkp_data [mpram_pkg::NRD];

   // ======================================================================
   // Write port
   // ======================================================================
   mpram_write_port u_wr
   (
      .clk     (clk),
      .arst_n  (arst_n),
      .we_n    (we_n),
      .wad     (wad),
      .din     (din),
      .wr_req  (wr_req),
      .wr_err  (wr_err),
      .wr_busy (wr_busy)
   );

   // ======================================================================
   // Storage array
   // ======================================================================
   mpram_5r1w u_mem
   (
      .clk      (clk),
      .arst_n   (arst_n),
      .wr_req   (wr_req),
      .lkp_addr (lkp_addr),
      .lkp_data (lkp_data)
   );

   // ======================================================================
   // Read ports
   // ======================================================================
   for (genvar i = 0; i < mpram_pkg::NRD; i++)
   begin : g_rd
      mpram_read_port u_rd
      (
         .clk      (clk),
         .arst_n   (arst_n),
         .oe_n     (oe_n[i]),
         .rad      (rad[i]),
         .lkp_data (lkp_data[i]),
         .lkp_addr (lkp_addr[i]),
         .rd_rsp   (rd_rsp[i])
      );
   end

endmodule

// ==== hdl/mpram_write_port.sv ====
`timescale 1ns/1ns

module mpram_write_port
(
   input  logic               clk,
   input  logic               arst_n,
   input  logic               we_n,     // Active low write enable
   input  mpram_pkg::addr_t   wad,
   input  mpram_pkg::data_t   din,
   output mpram_pkg::wr_req_t wr_req,
   output logic               wr_err,   // Sticky flag for dropped writes
   output logic               wr_busy
);

   logic             wr_valid_q;
   mpram_pkg::addr_t wr_addr_q;
   mpram_pkg::data_t wr_data_q;
   logic             wad_ok;

   assign wad_ok = mpram_pkg::addr_ok(wad);

   // ======================================================================
   // Request register
   // ======================================================================
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_valid_q <= 1'b0;
         wr_err     <= 1'b0;
      end
      else
      begin
         wr_valid_q <= !we_n && wad_ok;
         if (!we_n && !wad_ok)
            wr_err <= 1'b1;  // Held until reset
      end
   end

   always_ff @(posedge clk)
   begin
      wr_addr_q <= wad;
      wr_data_q <= din;
   end

   assign wr_req  = '{valid: wr_valid_q, addr: wr_addr_q, data: wr_data_q};
   assign wr_busy = wr_valid_q;  // Array commits on the next edge

   // Only legal writes reach the array
   a_wr_range: assert property (
      @(posedge clk) disable iff (!arst_n)
      wr_req.valid |-> mpram_pkg::addr_ok(wr_req.addr)
   );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_mpram \
   -f sources.f -Mdir obj_dir -o sim_mpram \
   || { echo "Build failed"; exit 1; }

out=$(./obj_dir/sim_mpram)
echo "$out"
echo "$out" | grep -qx "NO ERRORS" && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

// ==== sources.f ====
hdl/mpram_pkg.sv
hdl/mpram_write_port.sv
hdl/mpram_5r1w.sv
hdl/mpram_read_port.sv
hdl/mpram_top.sv
tests/tb_mpram.sv

// ==== tests/mpram_cases.txt ====
# name      op     port  addr  data  expect   (port is decimal, the rest hex)
# rdall uses port as the address stride, rand as the cycle count, rd expects {valid,err,data}
reset_rd    rdall  1     00    00    000
reset_rd    rdall  1     05    00    000
reset_rd    rdall  1     0a    00    000
reset_rd    rdall  1     0f    00    000
reset_rd    rdall  1     14    00    000
wr_rd       wr     0     03    5a    000
wr_rd       rd     0     03    00    25a
wr_rd       wr     0     07    c3    000
wr_rd       rd     1     07    00    2c3
wr_rd       wr     0     17    81    000
wr_rd       rd     2     17    00    281
wr_rd       rd     3     03    00    25a
wr_rd       wr     0     00    11    000
wr_rd       rd     4     00    00    211
par_rd      rdall  4     00    00    000
par_rd      rdall  0     03    00    000
par_rd      rdall  0     17    00    000
par_rd      rdall  1     00    00    000
par_rd      rd     1     03    00    25a
par_rd      rd     1     07    00    2c3
par_rd      rd     1     17    00    281
oe          dis    0     07    00    000
oe          dis    2     03    00    000
oe          dis    4     17    00    000
oe          dis    1     00    00    000
bad_addr    rd     0     18    00    300
bad_addr    rd     3     1f    00    300
bad_addr    wr     0     18    ee    000
bad_addr    wr     0     1e    ee    000
bad_addr    rd     0     00    00    211
bad_addr    rdall  1     16    00    000
rand        rand   40    00    00    000
rand        rand   40    00    00    000

// ==== tests/tb_mpram.sv ====
`timescale 1ns/1ns

module tb_mpram;

   typedef mpram_pkg::rd_rsp_t rsp_t;

   logic                      clk = 1'b0;
   logic                      arst_n;
   logic                      we_n;
   mpram_pkg::addr_t          wad;
   mpram_pkg::data_t          din;
   logic [mpram_pkg::NRD-1:0] oe_n;
   mpram_pkg::addr_t          rad    [mpram_pkg::NRD];
   rsp_t                      rd_rsp [mpram_pkg::NRD];
   logic                      wr_err;
   logic                      wr_busy;

   // Stimulus for the next cycle
   logic                      nx_we_n;
   mpram_pkg::addr_t          nx_wad;
   mpram_pkg::data_t          nx_din;
   logic [mpram_pkg::NRD-1:0] nx_oe_n;
   mpram_pkg::addr_t          nx_rad [mpram_pkg::NRD];
   int                        file_port;     // Port whose response comes from the case file
   rsp_t                      file_exp;

   // ======================================================================
   // Reference model
   // ======================================================================
   mpram_pkg::data_t shadow [mpram_pkg::WORDS];
   rsp_t             exp_q  [mpram_pkg::NRD][$];  // Responses in flight per port
   logic             err_model, err_seen, busy_model, busy_seen;

   int          seed = 32'h57cc_dd93;
   int          limit_cycles = 0;
   int          fd, n_lines, port, n_pass, n_fail, test_checks, test_errs;
   string       line, name, op, cur_name;
   logic [31:0] addr_v, data_v, exp_v;

   mpram_top DUT
   (
      .clk     (clk),
      .arst_n  (arst_n),
      .we_n    (we_n),
      .wad     (wad),
      .din     (din),
      .wr_err  (wr_err),
      .wr_busy (wr_busy),
      .oe_n    (oe_n),
      .rad     (rad),
      .rd_rsp  (rd_rsp)
   );

   always #20 clk = ~clk;

   task automatic check_value(input string tag, input logic [31:0] expected,
                              input logic [31:0] actual);
      test_checks++;
      if (actual !== expected)
      begin
         test_errs++;
         $display("Error: test %s expected %h actual %h", tag, expected, actual);
      end
   endtask

   function automatic rsp_t model_rsp(input logic off, input mpram_pkg::addr_t addr);
      rsp_t r;
      r = '0;
      if (!off)
      begin
         r.valid = 1'b1;
         if (addr >= mpram_pkg::WORDS)
            r.err = 1'b1;      // Out of range reads carry no data
         else
            r.data = shadow[addr];
      end
      return r;
   endfunction

   function automatic logic is_case(input string s);
      return s.len() > 2 && s.getc(0) != 8'h23;
   endfunction

   // One clock cycle: drive on the rising edge, check on the falling edge
   task automatic step();
      rsp_t e;
      @(posedge clk);
      we_n <= nx_we_n;
      wad  <= nx_wad;
      din  <= nx_din;
      oe_n <= nx_oe_n;
      for (int i = 0; i < mpram_pkg::NRD; i++)
      begin
         rad[i] <= nx_rad[i];
         e = model_rsp(nx_oe_n[i], nx_rad[i]);
         if (i == file_port)
            e = file_exp;
         exp_q[i].push_back(e);
      end
      // Reads in this cycle still see the old word
      err_seen   = err_model;
      busy_seen  = busy_model;
      busy_model = !nx_we_n && nx_wad < mpram_pkg::WORDS;
      if (!nx_we_n && nx_wad < mpram_pkg::WORDS)
         shadow[nx_wad] = nx_din;
      else if (!nx_we_n)
         err_model = 1'b1;
      @(negedge clk);
      for (int i = 0; i < mpram_pkg::NRD; i++)
      begin
         if (exp_q[i].size() > 2)
         begin
            e = exp_q[i].pop_front();
            check_value($sformatf("%s/rd_rsp%0d", cur_name, i), e, rd_rsp[i]);
         end
      end
      check_value({cur_name, "/wr_err"}, err_seen, wr_err);
      check_value({cur_name, "/wr_busy"}, busy_seen, wr_busy);
      nx_we_n   = 1'b1;
      nx_oe_n   = '1;
      file_port = -1;
   endtask

   task automatic random_cycle();
      logic [31:0] r;
      r       = $random(seed);
      nx_we_n = r[0];
      nx_wad  = r[5:1];
      nx_din  = r[13:6];
      nx_oe_n = r[18:14];
      for (int i = 0; i < mpram_pkg::NRD; i++)
      begin
         r         = $random(seed);
         nx_rad[i] = r[4:0];
      end
   endtask

   task automatic run_op();
      if (op == "wr")
      begin
         nx_we_n = 1'b0;
         nx_wad  = addr_v[4:0];
         nx_din  = data_v[7:0];
         step();
      end
      else if (op == "rd")
      begin
         nx_oe_n[port] = 1'b0;
         nx_rad[port]  = addr_v[4:0];
         file_port     = port;
         file_exp      = exp_v[9:0];
         step();
      end
      else if (op == "rdall" || op == "dis")
      begin
         for (int i = 0; i < mpram_pkg::NRD; i++)
         begin
            nx_oe_n[i] = (op == "dis") && (i == port);
            nx_rad[i]  = (op == "dis") ? addr_v[4:0] : mpram_pkg::addr_t'(addr_v + i * port);
         end
         step();
      end
      else if (op == "rand")
      begin
         repeat (port)
         begin
            random_cycle();
            step();
         end
      end
      else
      begin
         $display("Unknown operation %s in the case file", op);
         test_errs++;
      end
   endtask

   // Two idle cycles drain the read pipeline
   task automatic finish_test();
      step();
      step();
      if (test_errs == 0)
         n_pass++;
      else
         n_fail++;
      $display("Test %s: %0d checks, %0d errors", cur_name, test_checks, test_errs);
      test_checks = 0;
      test_errs   = 0;
   endtask

   // ======================================================================
   // Watchdog
   // ======================================================================
   initial
   begin
      wait (limit_cycles > 0);
      repeat (limit_cycles) @(posedge clk);
      $display("Simulation timed out after %0d cycles", limit_cycles);
      $display("ERRORS FOUND");
      $finish;
   end

   // ======================================================================
   // Main sequence
   // ======================================================================
   initial
   begin
      arst_n = 1'b0;
      we_n   = 1'b1;
      wad    = '0;
      din    = '0;
      oe_n   = '1;
      nx_we_n = 1'b1;
      nx_wad  = '0;
      nx_din  = '0;
      nx_oe_n = '1;
      file_port = -1;
      file_exp  = '0;
      err_model  = 1'b0;
      busy_model = 1'b0;
      n_lines = 0;
      n_pass  = 0;
      n_fail  = 0;
      test_checks = 0;
      test_errs   = 0;
      for (int i = 0; i < mpram_pkg::NRD; i++)
      begin
         rad[i]    = '0;
         nx_rad[i] = '0;
      end
      for (int w = 0; w < mpram_pkg::WORDS; w++)
         shadow[w] = '0;

      fd = $fopen("tests/mpram_cases.txt", "r");
      while (fd != 0 && !$feof(fd))
         if ($fgets(line, fd) != 0 && is_case(line))
            n_lines++;
      if (fd != 0)
         $fclose(fd);
      limit_cycles = n_lines * 64 + 10;

      repeat (10) @(posedge clk);
      arst_n <= 1'b1;
      @(negedge clk);
      cur_name = "reset";
      for (int i = 0; i < mpram_pkg::NRD; i++)
         check_value($sformatf("reset/rd_rsp%0d", i), 0, rd_rsp[i]);
      check_value("reset/wr_err", 0, wr_err);

      fd = $fopen("tests/mpram_cases.txt", "r");
      if (fd == 0)
      begin
         $display("Cannot open the case file tests/mpram_cases.txt");
         n_fail++;
      end
      while (fd != 0 && !$feof(fd))
      begin
         if ($fgets(line, fd) != 0 && is_case(line))
         begin
            if ($sscanf(line, "%s %s %d %h %h %h", name, op, port, addr_v, data_v, exp_v) != 6)
            begin
               $display("Malformed line in the case file: %s", line);
               test_errs++;
            end
            else
            begin
               if (name != cur_name)
               begin
                  finish_test();
                  cur_name = name;
               end
               run_op();
            end
         end
      end
      finish_test();

      $display("Summary: %0d tests passed, %0d tests failed", n_pass, n_fail);
      if (n_fail == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule
